/* sources.f */
rtl/osd_pkg.sv
rtl/osd_cmd_decoder.sv
rtl/osd_config_regs.sv
rtl/osd_video_gen.sv
rtl/host_write_fifo.sv
rtl/host_write_master.sv
rtl/osd_ctrl_top.sv
verif/osd_ctrl_tb.sv

/* Bender.yml */
package:
  name: osd_ctrl

sources:
  - rtl/osd_pkg.sv
  - rtl/osd_cmd_decoder.sv
  - rtl/osd_config_regs.sv
  - rtl/osd_video_gen.sv
  - rtl/host_write_fifo.sv
  - rtl/host_write_master.sv
  - rtl/osd_ctrl_top.sv
  - target: test
    files:
      - verif/osd_ctrl_tb.sv

/* verif/osd_ctrl_tb.sv */
// FIFO_DEPTH 4 and default beam widths; fills all 8 OSD lines before the checked frame
`timescale 1ns/1ps

module osd_ctrl_tb;

  localparam int FIFO_DEPTH    = 4;
  localparam int REG_ROUNDS    = 24;
  localparam int MEM_ROUNDS    = 6;
  localparam int MAX_WORDS     = 12;
  localparam int ACK_MAX_DELAY = 7;
  localparam int LINE_LONG     = 1420;
  localparam int FRAME_CYCLES  = 126 * 5 + 70 * (LINE_LONG + 1);
  localparam int MEM_CYCLES    = (MEM_ROUNDS + 1) * (4 + 2 * MAX_WORDS) * (ACK_MAX_DELAY + 4);
  localparam int LIMIT_CYCLES  = 8 + REG_ROUNDS * 8 + 10 * 260 + FRAME_CYCLES + MEM_CYCLES + 500;

  logic clk = 1'b0;
  logic reset, chip_reset, rx_valid, rx_cmd, sol, sof, host_ack;
  osd_pkg::byte_t rx_data;
  logic credit_return, usr_reset, cpu_reset, cpu_halt, osd_enable, key_disable;
  logic [4:0] chipset_config;
  logic [6:0] memory_config;
  logic [1:0] scanline, lr_filter, hr_filter, dither, host_bs;
  logic osd_blank, osd_pixel, host_cs, host_we;
  osd_pkg::host_addr_t host_adr;
  osd_pkg::host_data_t host_wdat;

  // ---------------------------------------------------------------------
  // model state
  // ---------------------------------------------------------------------
  integer seed = 32'h395;
  logic [2:0] m_rst;
  logic [1:0] m_osd;
  logic [7:0] m_video;
  logic [4:0] m_chip_stage, m_chip_out;
  logic [6:0] m_mem_stage, m_mem_out;
  osd_pkg::byte_t model_buf [0:2047];
  osd_pkg::host_data_t exp_q[$];
  osd_pkg::host_addr_t exp_addr;
  int credits = FIFO_DEPTH;
  int credit_pulses = 0;
  int words_done = 0;
  logic ack_hold = 1'b0;
  logic video_check = 1'b0;
  // beam model and its 2-stage output pipe
  int mh, mv;
  logic mph, men, p1_blank, p1_pix, p2_blank, p2_pix;

  osd_ctrl_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .H_COUNT_W  (11),
    .V_COUNT_W  (10)
  ) osd_ctrl_top_inst (
    .clk (clk), .reset (reset), .chip_reset (chip_reset), .rx_valid (rx_valid),
    .rx_cmd (rx_cmd), .rx_data (rx_data), .sol (sol), .sof (sof), .host_ack (host_ack),
    .credit_return (credit_return), .usr_reset (usr_reset), .cpu_reset (cpu_reset),
    .cpu_halt (cpu_halt), .osd_enable (osd_enable), .key_disable (key_disable),
    .chipset_config (chipset_config), .memory_config (memory_config),
    .scanline (scanline), .lr_filter (lr_filter), .hr_filter (hr_filter),
    .dither (dither), .osd_blank (osd_blank), .osd_pixel (osd_pixel),
    .host_cs (host_cs), .host_we (host_we), .host_bs (host_bs),
    .host_adr (host_adr), .host_wdat (host_wdat)
  );

  always #50 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    string line;
    if (got !== exp) begin
      line = $sformatf("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
      report_failure(line);
    end
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic send_byte(input logic is_cmd, input osd_pkg::byte_t data);
    rx_valid = 1'b1;
    rx_cmd   = is_cmd;
    rx_data  = data;
    @(posedge clk);
    #1;
    rx_valid = 1'b0;
    rx_cmd   = 1'b0;
    rx_data  = 8'h00;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic pulse_beam(input logic line_start, input logic frame_start);
    sol = line_start;
    sof = frame_start;
    @(posedge clk);
    #1;
    sol = 1'b0;
    sof = 1'b0;
  endtask

  task automatic check_regs();
    check("usr_reset", usr_reset, m_rst[0]);
    check("cpu_reset", cpu_reset, m_rst[1]);
    check("cpu_halt", cpu_halt, m_rst[2]);
    check("osd_enable", osd_enable, m_osd[0]);
    check("key_disable", key_disable, m_osd[1]);
    check("scanline", scanline, m_video[1:0]);
    check("lr_filter", lr_filter, m_video[3:2]);
    check("hr_filter", hr_filter, m_video[5:4]);
    check("dither", dither, m_video[7:6]);
    check("chipset_config", chipset_config, m_chip_out);
    check("memory_config", memory_config, m_mem_out);
  endtask

  // address goes low byte first and the low byte of each pair costs a credit
  task automatic mem_address(input osd_pkg::host_addr_t addr);
    send_byte(1'b1, {osd_pkg::CMD_MEM_WRITE, 2'b00});
    send_byte(1'b0, addr[7:0]);
    send_byte(1'b0, addr[15:8]);
    exp_addr = addr;
    send_byte(1'b0, addr[23:16]);
  endtask

  task automatic mem_word(input osd_pkg::host_data_t word);
    send_byte(1'b0, word[15:8]);
    while (credits == 0) begin
      @(posedge clk);
      #1;
    end
    credits--;
    exp_q.push_back(word);
    send_byte(1'b0, word[7:0]);
  endtask

  task automatic drain_writes();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    idle(4);
  endtask

  // ---------------------------------------------------------------------
  // beam model of the 448..703 by 128..191 window
  // ---------------------------------------------------------------------
  always @(posedge clk) begin : beam_model
    logic win;
    osd_pkg::byte_t row_byte;
    win = (mh >= osd_pkg::OSD_H_START) && (mh < osd_pkg::OSD_H_START + osd_pkg::OSD_WIDTH) &&
          (mv >= osd_pkg::OSD_V_START) && (mv < osd_pkg::OSD_V_START + osd_pkg::OSD_HEIGHT) &&
          men;
    row_byte = 8'h00;
    if (win) begin
      row_byte = model_buf[((mv - osd_pkg::OSD_V_START) / 8) * 256 + mh - osd_pkg::OSD_H_START];
    end
    if (reset) begin
      mh = 0;
      mph = 1'b0;
      mv = 0;
      men = 1'b0;
      p1_blank <= 1'b0;
      p1_pix   <= 1'b0;
      p2_blank <= 1'b0;
      p2_pix   <= 1'b0;
    end else begin
      p1_blank <= win;
      p1_pix   <= win && row_byte[(mv - osd_pkg::OSD_V_START) % 8];
      p2_blank <= p1_blank;
      p2_pix   <= p1_pix;
      if (sol) begin
        mh = 0;
        mph = 1'b0;
      end else begin
        // 11-bit counter wraps
        if (mph) mh = (mh + 1) % 2048;
        mph = !mph;
      end
      if (sof) begin
        mv = 0;
        men = m_osd[0];
      end else if (sol) begin
        mv = (mv + 1) % 1024;
      end
    end
  end

  always @(negedge clk) begin
    if (video_check) begin
      check("osd_blank", osd_blank, p2_blank);
      check("osd_pixel", osd_pixel, p2_pix);
    end
  end

  always @(posedge clk) begin
    if (!reset && credit_return) begin
      credits++;
      credit_pulses++;
    end
  end

  // ---------------------------------------------------------------------
  // host bus responder with random ack delay
  // ---------------------------------------------------------------------
  initial begin : bus_responder
    int delay;
    forever begin
      @(negedge clk);
      if (host_cs && !ack_hold) begin
        delay = {$random(seed)} % (ACK_MAX_DELAY + 1);
        repeat (delay) @(negedge clk);
        @(posedge clk);
        #1 host_ack = 1'b1;
        @(negedge clk);
        // request must still be held on the ack cycle
        check("host_cs", host_cs, 1'b1);
        if (exp_q.size() == 0) report_failure("host write seen with no word expected");
        check("host_wdat", host_wdat, exp_q[0]);
        check("host_adr", host_adr, exp_addr);
        check("host_bs", host_bs, 2'b11);
        check("host_we", host_we, 1'b1);
        void'(exp_q.pop_front());
        exp_addr = exp_addr + 24'd2;
        words_done++;
        @(posedge clk);
        #1 host_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(LIMIT_CYCLES * 100.0);
    report_failure("watchdog expired, the DUT stopped making progress");
  end

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------
  initial begin : main_sequence
    int sel;
    int n;
    osd_pkg::byte_t d;
    osd_pkg::byte_t code;
    osd_pkg::host_addr_t abort_addr;
    reset = 1'b1;
    chip_reset = 1'b0;
    rx_valid = 1'b0;
    rx_cmd = 1'b0;
    rx_data = 8'h00;
    sol = 1'b0;
    sof = 1'b0;
    host_ack = 1'b0;
    m_rst = 3'b110;
    m_osd = 2'b00;
    m_video = 8'h00;
    m_chip_stage = 5'd0;
    m_chip_out = 5'd0;
    m_mem_stage = osd_pkg::MEMORY_CFG_RESET;
    m_mem_out = osd_pkg::MEMORY_CFG_RESET;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;

    // reset values
    @(negedge clk);
    check_regs();
    check("host_cs", host_cs, 1'b0);
    check("host_we", host_we, 1'b0);
    check("host_bs", host_bs, 2'b00);
    check("credit_return", credit_return, 1'b0);
    check("osd_blank", osd_blank, 1'b0);
    check("osd_pixel", osd_pixel, 1'b0);
    @(posedge clk);
    #1;

    // direct register writes and ignored later bytes
    repeat (REG_ROUNDS) begin
      sel = {$random(seed)} % 3;
      code = (sel == 0) ? {osd_pkg::CMD_RESET_CTRL, 2'b00} :
             (sel == 1) ? {osd_pkg::CMD_OSD_CTRL, 2'b00} : {osd_pkg::CMD_VIDEO_CFG, 2'b00};
      code[1:0] = $random(seed);
      send_byte(1'b1, code);
      d = $random(seed);
      send_byte(1'b0, d);
      if (sel == 0) m_rst = d[2:0];
      else if (sel == 1) m_osd = d[1:0];
      else m_video = d;
      check_regs();
      send_byte(1'b0, $random(seed));
      send_byte(1'b0, $random(seed));
      check_regs();
    end

    // staged configuration waits for chip_reset
    repeat (4) begin
      send_byte(1'b1, {osd_pkg::CMD_CHIP_CFG, 2'b00});
      d = $random(seed);
      send_byte(1'b0, d);
      m_chip_stage = d[4:0];
      send_byte(1'b1, {osd_pkg::CMD_MEMORY_CFG, 2'b00});
      d = $random(seed);
      send_byte(1'b0, d);
      m_mem_stage = d[6:0];
      idle(3);
      check_regs();
      chip_reset = 1'b1;
      idle(1);
      chip_reset = 1'b0;
      m_chip_out = m_chip_stage;
      m_mem_out = m_mem_stage;
      check_regs();
    end

    // OSD bitmap fill of every line and then one random line again
    for (int k = 0; k < 9; k++) begin
      n = (k < 8) ? k : {$random(seed)} % 8;
      send_byte(1'b1, {osd_pkg::CMD_OSD_BUFFER, 2'b00});
      send_byte(1'b0, 8'(n));
      for (int i = 0; i < 256; i++) begin
        d = $random(seed);
        model_buf[n * 256 + i] = d;
        send_byte(1'b0, d);
      end
    end
    send_byte(1'b1, {osd_pkg::CMD_OSD_CTRL, 2'b00});
    send_byte(1'b0, 8'h01);
    m_osd = 2'b01;
    idle(3);

    // one frame with short lines above the window
    video_check = 1'b1;
    pulse_beam(1'b1, 1'b1);
    for (int l = 0; l < 196; l++) begin
      idle((l >= 126) ? LINE_LONG : 4);
      pulse_beam(1'b1, 1'b0);
    end
    idle(4);
    video_check = 1'b0;

    // memory writes with credits
    repeat (MEM_ROUNDS) begin
      mem_address($random(seed));
      n = 1 + {$random(seed)} % MAX_WORDS;
      repeat (n) mem_word($random(seed));
      drain_writes();
    end

    // abort a pending write so its words go to the next address
    ack_hold = 1'b1;
    mem_address($random(seed));
    repeat (3) mem_word($random(seed));
    while (host_cs !== 1'b1) idle(1);
    send_byte(1'b1, {osd_pkg::CMD_MEM_WRITE, 2'b00});
    idle(4);
    check("host_cs", host_cs, 1'b0);
    abort_addr = $random(seed);
    send_byte(1'b0, abort_addr[7:0]);
    send_byte(1'b0, abort_addr[15:8]);
    exp_addr = abort_addr;
    send_byte(1'b0, abort_addr[23:16]);
    ack_hold = 1'b0;
    drain_writes();

    check("credit_return pulses", credit_pulses, words_done);
    check("credits", credits, FIFO_DEPTH);
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* rtl/osd_ctrl_top.sv */
// byte stream input is parallel; host must spend a credit for each byte that completes a word
`timescale 1ns/1ps

module osd_ctrl_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int H_COUNT_W  = 11,
  parameter int V_COUNT_W  = 10
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                chip_reset,
  input  logic                rx_valid,
  input  logic                rx_cmd,
  input  osd_pkg::byte_t      rx_data,
  input  logic                sol,
  input  logic                sof,
  input  logic                host_ack,
  output logic                credit_return,
  output logic                usr_reset,
  output logic                cpu_reset,
  output logic                cpu_halt,
  output logic                osd_enable,
  output logic                key_disable,
  output logic [4:0]          chipset_config,
  output logic [6:0]          memory_config,
  output logic [1:0]          scanline,
  output logic [1:0]          lr_filter,
  output logic [1:0]          hr_filter,
  output logic [1:0]          dither,
  output logic                osd_blank,
  output logic                osd_pixel,
  output logic                host_cs,
  output logic                host_we,
  output logic [1:0]          host_bs,
  output osd_pkg::host_addr_t host_adr,
  output osd_pkg::host_data_t host_wdat
);

  // decoder to registers
  logic                cfg_we;
  osd_pkg::cmd_t       cfg_cmd;
  osd_pkg::byte_t      cfg_data;
  // decoder to bitmap
  logic                buf_we;
  osd_pkg::buf_addr_t  buf_addr;
  osd_pkg::byte_t      buf_data;
  // memory write path
  logic                fifo_push;
  osd_pkg::host_data_t fifo_data;
  logic                mem_addr_load;
  osd_pkg::host_addr_t mem_addr;
  logic                cmd_start;
  logic                fifo_pop;
  logic                fifo_empty;
  osd_pkg::host_data_t fifo_rd_data;

  // ----------------------------------------------------------------------
  // command side
  // ----------------------------------------------------------------------
  osd_cmd_decoder osd_cmd_decoder_inst (
    .clk           (clk),
    .reset         (reset),
    .rx_valid      (rx_valid),
    .rx_cmd        (rx_cmd),
    .rx_data       (rx_data),
    .cfg_we        (cfg_we),
    .cfg_cmd       (cfg_cmd),
    .cfg_data      (cfg_data),
    .buf_we        (buf_we),
    .buf_addr      (buf_addr),
    .buf_data      (buf_data),
    .fifo_push     (fifo_push),
    .fifo_data     (fifo_data),
    .mem_addr_load (mem_addr_load),
    .mem_addr      (mem_addr),
    .cmd_start     (cmd_start)
  );

  osd_config_regs osd_config_regs_inst (
    .clk            (clk),
    .reset          (reset),
    .chip_reset     (chip_reset),
    .cfg_we         (cfg_we),
    .cfg_cmd        (cfg_cmd),
    .cfg_data       (cfg_data),
    .usr_reset      (usr_reset),
    .cpu_reset      (cpu_reset),
    .cpu_halt       (cpu_halt),
    .osd_enable     (osd_enable),
    .key_disable    (key_disable),
    .chipset_config (chipset_config),
    .memory_config  (memory_config),
    .scanline       (scanline),
    .lr_filter      (lr_filter),
    .hr_filter      (hr_filter),
    .dither         (dither)
  );

  // ----------------------------------------------------------------------
  // video overlay
  // ----------------------------------------------------------------------
  osd_video_gen #(
    .H_COUNT_W (H_COUNT_W),
    .V_COUNT_W (V_COUNT_W)
  ) osd_video_gen_inst (
    .clk        (clk),
    .reset      (reset),
    .sol        (sol),
    .sof        (sof),
    .osd_enable (osd_enable),
    .buf_we     (buf_we),
    .buf_addr   (buf_addr),
    .buf_data   (buf_data),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

  // ----------------------------------------------------------------------
  // host bus writes
  // ----------------------------------------------------------------------
  host_write_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) host_write_fifo_inst (
    .clk           (clk),
    .reset         (reset),
    .push          (fifo_push),
    .push_data     (fifo_data),
    .pop           (fifo_pop),
    .pop_data      (fifo_rd_data),
    .empty         (fifo_empty),
    .credit_return (credit_return)
  );

  host_write_master host_write_master_inst (
    .clk       (clk),
    .reset     (reset),
    .cmd_start (cmd_start),
    .addr_load (mem_addr_load),
    .load_addr (mem_addr),
    .empty     (fifo_empty),
    .rd_data   (fifo_rd_data),
    .host_ack  (host_ack),
    .pop       (fifo_pop),
    .host_cs   (host_cs),
    .host_we   (host_we),
    .host_bs   (host_bs),
    .host_adr  (host_adr),
    .host_wdat (host_wdat)
  );

endmodule

/* rtl/host_write_master.sv */
// full-word writes only; after a new command nothing goes out until the next address is loaded
`timescale 1ns/1ps

module host_write_master (
  input  logic                clk,
  input  logic                reset,
  input  logic                cmd_start,
  input  logic                addr_load,
  input  osd_pkg::host_addr_t load_addr,
  input  logic                empty,
  input  osd_pkg::host_data_t rd_data,
  input  logic                host_ack,
  output logic                pop,
  output logic                host_cs,
  output logic                host_we,
  output logic [1:0]          host_bs,
  output osd_pkg::host_addr_t host_adr,
  output osd_pkg::host_data_t host_wdat
);

  osd_pkg::wr_state_t state;
  logic               addr_valid;

  // request held from state until ack
  assign host_cs   = (state == osd_pkg::WR_WRITE);
  assign host_we   = host_cs;
  assign host_bs   = {2{host_cs}};
  assign host_wdat = rd_data;
  // word leaves on the ack cycle, also during an abort
  assign pop       = host_cs && host_ack;

  // ----------------------------------------------------------------------
  // write FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= osd_pkg::WR_IDLE;
    end else if (cmd_start) begin
      state <= osd_pkg::WR_IDLE;
    end else begin
      case (state)
        osd_pkg::WR_IDLE: begin
          if (!empty && addr_valid) begin
            state <= osd_pkg::WR_WRITE;
          end
        end
        osd_pkg::WR_WRITE: begin
          if (host_ack) begin
            state <= osd_pkg::WR_IDLE;
          end
        end
        default: state <= osd_pkg::WR_IDLE;
      endcase
    end
  end

  // address counter, word steps of 2
  always_ff @(posedge clk) begin
    if (reset) begin
      addr_valid <= 1'b0;
      host_adr   <= '0;
    end else begin
      if (cmd_start) begin
        addr_valid <= 1'b0;
      end else if (addr_load) begin
        addr_valid <= 1'b1;
      end
      if (addr_load) begin
        host_adr <= load_addr;
      end else if (pop) begin
        host_adr <= host_adr + 24'd2;
      end
    end
  end

endmodule

/* rtl/host_write_fifo.sv */
// FIFO_DEPTH of 2 or more; no full check, the sender's credits keep pushes within depth
`timescale 1ns/1ps

module host_write_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  osd_pkg::host_data_t push_data,
  input  logic                pop,
  output osd_pkg::host_data_t pop_data,
  output logic                empty,
  output logic                credit_return
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  osd_pkg::host_data_t mem [0:FIFO_DEPTH-1];
  logic [ADDR_W-1:0]   wr_ptr;
  logic [ADDR_W-1:0]   rd_ptr;
  logic [ADDR_W:0]     count;
  logic                pop_ok;

  assign empty    = (count == '0);
  assign pop_ok   = pop && !empty;
  // head word, held until the pop
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at depth, not at a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // one credit back per word leaving
      credit_return <= pop_ok;
    end
  end

endmodule

/* rtl/osd_video_gen.sv */
// OSD beam follows sol/sof only, pixels at half clock rate; outputs lag the beam by 2 clocks
`timescale 1ns/1ps

module osd_video_gen #(
  parameter int H_COUNT_W = 11,
  parameter int V_COUNT_W = 10
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               sol,
  input  logic               sof,
  input  logic               osd_enable,
  input  logic               buf_we,
  input  osd_pkg::buf_addr_t buf_addr,
  input  osd_pkg::byte_t     buf_data,
  output logic               osd_blank,
  output logic               osd_pixel
);

  logic [H_COUNT_W-1:0] h_cnt;
  logic [V_COUNT_W-1:0] v_cnt;
  logic                 h_phase;
  logic                 osd_en_frame;
  logic [H_COUNT_W-1:0] h_off;
  logic [V_COUNT_W-1:0] v_off;
  logic                 h_win;
  logic                 v_win;
  osd_pkg::byte_t       osd_ram [0:2047];
  osd_pkg::byte_t       rd_byte;
  logic                 win_d1;
  logic [2:0]           bit_d1;

  // ----------------------------------------------------------------------
  // beam counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt   <= '0;
      h_phase <= 1'b0;
    end else if (sol) begin
      h_cnt   <= '0;
      h_phase <= 1'b0;
    end else begin
      // one OSD pixel per two clocks
      h_phase <= !h_phase;
      if (h_phase) begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      v_cnt        <= '0;
      osd_en_frame <= 1'b0;
    end else begin
      if (sof) begin
        v_cnt        <= '0;
        // enable only changes between frames
        osd_en_frame <= osd_enable;
      end else if (sol) begin
        v_cnt <= v_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // window decode
  // ----------------------------------------------------------------------
  assign h_off = h_cnt - H_COUNT_W'(osd_pkg::OSD_H_START);
  assign v_off = v_cnt - V_COUNT_W'(osd_pkg::OSD_V_START);

  assign h_win = (h_cnt >= H_COUNT_W'(osd_pkg::OSD_H_START)) &&
                 (h_cnt <  H_COUNT_W'(osd_pkg::OSD_H_START + osd_pkg::OSD_WIDTH));
  assign v_win = (v_cnt >= V_COUNT_W'(osd_pkg::OSD_V_START)) &&
                 (v_cnt <  V_COUNT_W'(osd_pkg::OSD_V_START + osd_pkg::OSD_HEIGHT));

  // ----------------------------------------------------------------------
  // bitmap buffer, one write port and one read port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (buf_we) begin
      osd_ram[buf_addr] <= buf_data;
    end
  end

  // stage 1: row of 8 lines per byte, column from h
  always_ff @(posedge clk) begin
    rd_byte <= osd_ram[{v_off[5:3], h_off[7:0]}];
    bit_d1  <= v_off[2:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      win_d1    <= 1'b0;
      osd_blank <= 1'b0;
      osd_pixel <= 1'b0;
    end else begin
      win_d1    <= h_win && v_win && osd_en_frame;
      // stage 2: pick the line bit
      osd_blank <= win_d1;
      osd_pixel <= win_d1 && rd_byte[bit_d1];
    end
  end

endmodule

/* rtl/osd_config_regs.sv */
// chipset and memory settings reach the core only while chip_reset is held high
`timescale 1ns/1ps

module osd_config_regs (
  input  logic           clk,
  input  logic           reset,
  input  logic           chip_reset,
  input  logic           cfg_we,
  input  osd_pkg::cmd_t  cfg_cmd,
  input  osd_pkg::byte_t cfg_data,
  output logic           usr_reset,
  output logic           cpu_reset,
  output logic           cpu_halt,
  output logic           osd_enable,
  output logic           key_disable,
  output logic [4:0]     chipset_config,
  output logic [6:0]     memory_config,
  output logic [1:0]     scanline,
  output logic [1:0]     lr_filter,
  output logic [1:0]     hr_filter,
  output logic [1:0]     dither
);

  // staged values, wait for chip_reset
  logic [4:0] chip_stage;
  logic [6:0] mem_stage;

  // ----------------------------------------------------------------------
  // direct registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      usr_reset   <= 1'b0;
      cpu_reset   <= 1'b1;
      cpu_halt    <= 1'b1;
      osd_enable  <= 1'b0;
      key_disable <= 1'b0;
      scanline    <= 2'b00;
      lr_filter   <= 2'b00;
      hr_filter   <= 2'b00;
      dither      <= 2'b00;
      chip_stage  <= 5'd0;
      mem_stage   <= osd_pkg::MEMORY_CFG_RESET;
    end else if (cfg_we) begin
      case (cfg_cmd)
        osd_pkg::CMD_RESET_CTRL: {cpu_halt, cpu_reset, usr_reset} <= cfg_data[2:0];
        osd_pkg::CMD_OSD_CTRL:   {key_disable, osd_enable} <= cfg_data[1:0];
        osd_pkg::CMD_VIDEO_CFG:  {dither, hr_filter, lr_filter, scanline} <= cfg_data;
        osd_pkg::CMD_CHIP_CFG:   chip_stage <= cfg_data[4:0];
        osd_pkg::CMD_MEMORY_CFG: mem_stage  <= cfg_data[6:0];
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // staged chipset and memory config
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      chipset_config <= 5'd0;
      memory_config  <= osd_pkg::MEMORY_CFG_RESET;
    end else if (chip_reset) begin
      // copied every clock while held
      chipset_config <= chip_stage;
      memory_config  <= mem_stage;
    end
  end

endmodule

/* rtl/osd_cmd_decoder.sv */
// byte stream arrives parallel, one byte per clock at most; FIFO overflow is left to sender credits
`timescale 1ns/1ps

module osd_cmd_decoder (
  input  logic                clk,
  input  logic                reset,
  input  logic                rx_valid,
  input  logic                rx_cmd,
  input  osd_pkg::byte_t      rx_data,
  output logic                cfg_we,
  output osd_pkg::cmd_t       cfg_cmd,
  output osd_pkg::byte_t      cfg_data,
  output logic                buf_we,
  output osd_pkg::buf_addr_t  buf_addr,
  output osd_pkg::byte_t      buf_data,
  output logic                fifo_push,
  output osd_pkg::host_data_t fifo_data,
  output logic                mem_addr_load,
  output osd_pkg::host_addr_t mem_addr,
  output logic                cmd_start
);

  osd_pkg::cmd_t      cmd;
  logic [1:0]         dat_cnt;
  logic               rx_dat;
  logic               reg_cmd;
  logic               buf_sel;
  logic               mem_sel;
  osd_pkg::buf_addr_t buf_ptr;
  logic               pair_hi;
  osd_pkg::byte_t     hi_byte;

  assign rx_dat  = rx_valid && !rx_cmd;
  assign buf_sel = rx_dat && (cmd == osd_pkg::CMD_OSD_BUFFER);
  assign mem_sel = rx_dat && (cmd == osd_pkg::CMD_MEM_WRITE);

  // ----------------------------------------------------------------------
  // command latch and data byte index
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd       <= osd_pkg::CMD_NOP;
      dat_cnt   <= 2'd0;
      cmd_start <= 1'b0;
    end else begin
      cmd_start <= rx_valid && rx_cmd;
      if (rx_valid && rx_cmd) begin
        // unknown codes are kept but select nothing
        cmd     <= osd_pkg::cmd_t'(rx_data[7:2]);
        dat_cnt <= 2'd0;
      end else if (rx_dat && (dat_cnt != 2'd3)) begin
        // saturates at 3
        dat_cnt <= dat_cnt + 2'd1;
      end
    end
  end

  // register commands take only the first data byte
  always_comb begin
    case (cmd)
      osd_pkg::CMD_RESET_CTRL,
      osd_pkg::CMD_OSD_CTRL,
      osd_pkg::CMD_CHIP_CFG,
      osd_pkg::CMD_MEMORY_CFG,
      osd_pkg::CMD_VIDEO_CFG: reg_cmd = 1'b1;
      default:                reg_cmd = 1'b0;
    endcase
  end

  // same cycle as the byte, registers latch it at the edge
  assign cfg_we   = rx_dat && reg_cmd && (dat_cnt == 2'd0);
  assign cfg_cmd  = cmd;
  assign cfg_data = rx_data;

  // ----------------------------------------------------------------------
  // OSD buffer writes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      buf_we <= 1'b0;
    end else begin
      buf_we <= buf_sel && (dat_cnt != 2'd0);
    end
  end

  always_ff @(posedge clk) begin
    if (buf_sel) begin
      if (dat_cnt == 2'd0) begin
        // line number selects a 256-byte row
        buf_ptr <= {rx_data[2:0], 8'h00};
      end else begin
        buf_addr <= buf_ptr;
        buf_data <= rx_data;
        // wraps within 11 bits
        buf_ptr  <= buf_ptr + 11'd1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // memory writes, 3 address bytes then high/low pairs
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_addr_load <= 1'b0;
      fifo_push     <= 1'b0;
      pair_hi       <= 1'b0;
    end else begin
      mem_addr_load <= mem_sel && (dat_cnt == 2'd2);
      fifo_push     <= mem_sel && (dat_cnt == 2'd3) && pair_hi;
      if (rx_valid && rx_cmd) begin
        pair_hi <= 1'b0;
      end else if (mem_sel && (dat_cnt == 2'd3)) begin
        pair_hi <= !pair_hi;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_sel) begin
      case (dat_cnt)
        // address low byte first
        2'd0: mem_addr[7:0]   <= rx_data;
        2'd1: mem_addr[15:8]  <= rx_data;
        2'd2: mem_addr[23:16] <= rx_data;
        default: begin
          if (!pair_hi) begin
            hi_byte <= rx_data;
          end else begin
            fifo_data <= {hi_byte, rx_data};
          end
        end
      endcase
    end
  end

endmodule

/* rtl/osd_pkg.sv */
// shared widths and codes; OSD window is fixed at 256x64 and command codes use bits 7:2 only
package osd_pkg;

  // ----------------------------------------------------------------------
  // data widths
  // ----------------------------------------------------------------------

  // one byte of the host command stream
  typedef logic [7:0]  byte_t;
  // 2048-byte OSD bitmap
  typedef logic [10:0] buf_addr_t;
  // host bus byte address, no page byte
  typedef logic [23:0] host_addr_t;
  // host bus write word
  typedef logic [15:0] host_data_t;

  // ----------------------------------------------------------------------
  // command codes, upper 6 bits of a command byte
  // ----------------------------------------------------------------------
  typedef enum logic [5:0] {
    CMD_NOP        = 6'b000000,
    CMD_RESET_CTRL = 6'b000010,
    CMD_OSD_CTRL   = 6'b001010,
    CMD_CHIP_CFG   = 6'b000001,
    CMD_MEMORY_CFG = 6'b001001,
    CMD_VIDEO_CFG  = 6'b001101,
    CMD_OSD_BUFFER = 6'b000011,
    CMD_MEM_WRITE  = 6'b000111
  } cmd_t;

  // host write FSM
  typedef enum logic [0:0] {
    WR_IDLE  = 1'b0,
    WR_WRITE = 1'b1
  } wr_state_t;

  // ----------------------------------------------------------------------
  // OSD window in beam counts
  // ----------------------------------------------------------------------
  localparam int OSD_H_START = 448;
  localparam int OSD_WIDTH   = 256;
  localparam int OSD_V_START = 128;
  localparam int OSD_HEIGHT  = 64;

  // chip ram 512k, slow ram 512k at power up
  localparam logic [6:0] MEMORY_CFG_RESET = 7'b0000101;

endpackage
